// File: lotr_cfg.svh
// Address map assumes 32-bit byte addresses, an 8-bit core ID, 2 region bits and word-wide RAM
`ifndef LOTR_CFG_SVH
`define LOTR_CFG_SVH

// ===================================================================
// Address fields
// ===================================================================

// Core ID lives in the top byte of the address
`define LOTR_MSB_CORE_ID 31
`define LOTR_LSB_CORE_ID 24

// Region select just below the core ID
`define LOTR_MSB_REGION 23
`define LOTR_LSB_REGION 22

// Top bit of the RAM byte offset
// Bits 1..0 pick the byte lane, so the word index is 11..2
`define LOTR_MSB_D_MEM 11

// ===================================================================
// Region codes
// ===================================================================

`define LOTR_D_MEM_REGION 2'd1
`define LOTR_CR_REGION 2'd2

// ===================================================================
// Sizes
// ===================================================================

// Data RAM depth in 32-bit words, 4 KB in total
`define LOTR_D_MEM_WORDS 1024

// Top bit of the CR byte offset inside the CR region
`define LOTR_MSB_CR 7

`endif

// File: lotr_mem_pkg.sv
// Core request is fixed at 32-bit address and data; one request per cycle with no back-pressure
`default_nettype none

package lotr_mem_pkg;

    // ===================================================================
    // Core request
    // ===================================================================

    // Single-cycle request from the core
    // Valid in any cycle where rden or wren is high
    typedef struct packed {
        // Full byte address, core ID and region on top
        logic [31:0] address;
        // One bit per byte lane, bit 0 is data[7:0]
        logic [3:0]  byteena;
        // Write data
        logic [31:0] data;
        // Read request
        logic        rden;
        // Write request
        logic        wren;
    } t_mem_req;

    // ===================================================================
    // Read-data source
    // ===================================================================

    // Which block drives q in the cycle after a read
    // NONE also covers unmapped regions and other cores
    typedef enum logic [1:0] {
        RD_SRC_NONE  = 2'd0,
        RD_SRC_D_MEM = 2'd1,
        RD_SRC_CR    = 2'd2
    } t_rd_src;

endpackage

`default_nettype wire

// File: lotr_cr_pkg.sv
// CR file has only en_pc, rst_pc and a read-only core ID; offsets are byte offsets in the CR region
`default_nettype none

`include "lotr_cfg.svh"

package lotr_cr_pkg;

    // Control-register outputs toward the core
    typedef struct packed {
        // Let the PC advance
        logic en_pc;
        // Hold the PC in reset
        logic rst_pc;
    } t_cr;

    // ===================================================================
    // CR offsets
    // ===================================================================

    // Byte offset inside the CR region, word aligned
    typedef enum logic [`LOTR_MSB_CR:0] {
        // Read/write, bit 0 only
        CR_EN_PC   = 8'h00,
        // Read/write, bit 0 only
        CR_RST_PC  = 8'h04,
        // Read only, strap value
        CR_CORE_ID = 8'h08
    } t_cr_offset;

endpackage

`default_nettype wire

// File: d_mem.sv
// Behavioural RAM only; contents start undefined and a same-address read during a write sees old data
`default_nettype none

`include "lotr_cfg.svh"

module d_mem (
    input  logic                                 clock,
    // Word index, byte offset already stripped
    input  logic [$clog2(`LOTR_D_MEM_WORDS)-1:0] address,
    input  logic [3:0]                           byteena,
    input  logic [31:0]                          data,
    input  logic                                 rden,
    input  logic                                 wren,
    output logic [31:0]                          q
);

    // ===================================================================
    // Storage
    // ===================================================================

    logic [31:0] mem [`LOTR_D_MEM_WORDS];

    // ===================================================================
    // Write port
    // ===================================================================

    // Byte-masked write
    always_ff @(posedge clock) begin
        if (wren) begin
            for (int lane = 0; lane < 4; lane++) begin
                // Only enabled lanes are touched
                if (byteena[lane]) begin
                    mem[address][8*lane +: 8] <= data[8*lane +: 8];
                end
            end
        end
    end

    // ===================================================================
    // Read port
    // ===================================================================

    // Registered read, one cycle latency
    // Holds the last word while rden is low
    always_ff @(posedge clock) begin
        if (rden) begin
            q <= mem[address];
        end
    end

endmodule

`default_nettype wire

// File: cr_regs.sv
// Expects req already gated to the CR region and the local core; unknown offsets read zero
`default_nettype none

`include "lotr_cfg.svh"

module cr_regs (
    input  logic                  clock,
    input  logic                  rst,
    // Gated request, rden/wren only high on a local CR hit
    input  lotr_mem_pkg::t_mem_req req,
    // Strap value returned on CR_CORE_ID
    input  logic [7:0]            core_id,
    output logic [31:0]           rd_data,
    output lotr_cr_pkg::t_cr      cr
);

    // Decoded byte offset of this request
    lotr_cr_pkg::t_cr_offset offset;
    // Read value before the output register
    logic [31:0]             rd_next;

    // Low address byte picks the register
    assign offset = lotr_cr_pkg::t_cr_offset'(req.address[`LOTR_MSB_CR:0]);

    // ===================================================================
    // Register writes
    // ===================================================================

    // PC control bits, both cleared on reset
    always_ff @(posedge clock) begin
        if (rst) begin
            cr <= '0;
        end else if (req.wren) begin
            case (offset)
                lotr_cr_pkg::CR_EN_PC: begin
                    cr.en_pc <= req.data[0];
                end
                lotr_cr_pkg::CR_RST_PC: begin
                    cr.rst_pc <= req.data[0];
                end
                // Core ID is read only
                default: begin
                    cr <= cr;
                end
            endcase
        end
    end

    // ===================================================================
    // Register reads
    // ===================================================================

    // Select the addressed value
    always_comb begin
        rd_next = '0;
        case (offset)
            lotr_cr_pkg::CR_EN_PC: begin
                rd_next = {31'b0, cr.en_pc};
            end
            lotr_cr_pkg::CR_RST_PC: begin
                rd_next = {31'b0, cr.rst_pc};
            end
            lotr_cr_pkg::CR_CORE_ID: begin
                // Zero-extended strap
                rd_next = {24'b0, core_id};
            end
            default: begin
                rd_next = '0;
            end
        endcase
    end

    // Capture on read, value before any same-cycle write
    always_ff @(posedge clock) begin
        if (req.rden) begin
            rd_data <= rd_next;
        end
    end

endmodule

`default_nettype wire

// File: d_mem_wrap.sv
// Core ID 0 aliases the local core; other cores and unmapped regions read zero and drop writes
`default_nettype none

`include "lotr_cfg.svh"

module d_mem_wrap (
    input  logic                  clock,
    input  logic                  rst,
    input  lotr_mem_pkg::t_mem_req req,
    // Local core ID strap
    input  logic [7:0]            core_id,
    output logic [31:0]           q,
    output lotr_cr_pkg::t_cr      cr
);

    logic                  match_local_core;
    logic                  match_d_mem_region;
    logic                  match_cr_region;
    logic                  d_mem_hit;
    logic                  cr_hit;
    lotr_mem_pkg::t_mem_req cr_req;
    lotr_mem_pkg::t_rd_src  rd_src_next;
    lotr_mem_pkg::t_rd_src  rd_src;
    logic [31:0]           d_mem_q;
    logic [31:0]           cr_q;

    // ===================================================================
    // Address decode
    // ===================================================================

    always_comb begin
        // Broadcast ID 0 or our own strap
        match_local_core = (req.address[`LOTR_MSB_CORE_ID:`LOTR_LSB_CORE_ID] == 8'b0)
                        || (req.address[`LOTR_MSB_CORE_ID:`LOTR_LSB_CORE_ID] == core_id);
        match_d_mem_region = (req.address[`LOTR_MSB_REGION:`LOTR_LSB_REGION]
                              == `LOTR_D_MEM_REGION);
        match_cr_region    = (req.address[`LOTR_MSB_REGION:`LOTR_LSB_REGION]
                              == `LOTR_CR_REGION);
        d_mem_hit = match_local_core && match_d_mem_region;
        cr_hit    = match_local_core && match_cr_region;
    end

    // CR request with its enables gated
    always_comb begin
        cr_req      = req;
        cr_req.rden = req.rden && cr_hit;
        cr_req.wren = req.wren && cr_hit;
    end

    // ===================================================================
    // Targets
    // ===================================================================

    // Word index from byte offset bits 11..2
    d_mem u_d_mem (
        .clock   (clock),
        .address (req.address[`LOTR_MSB_D_MEM:2]),
        .byteena (req.byteena),
        .data    (req.data),
        .rden    (req.rden && d_mem_hit),
        .wren    (req.wren && d_mem_hit),
        .q       (d_mem_q)
    );

    cr_regs u_cr_regs (
        .clock   (clock),
        .rst     (rst),
        .req     (cr_req),
        .core_id (core_id),
        .rd_data (cr_q),
        .cr      (cr)
    );

    // ===================================================================
    // Read-data select
    // ===================================================================

    // Source of the data returned next cycle
    always_comb begin
        rd_src_next = lotr_mem_pkg::RD_SRC_NONE;
        if (req.rden && d_mem_hit) begin
            rd_src_next = lotr_mem_pkg::RD_SRC_D_MEM;
        end else if (req.rden && cr_hit) begin
            rd_src_next = lotr_mem_pkg::RD_SRC_CR;
        end
    end

    // Tracks the read every cycle, so back-to-back reads stay aligned
    always_ff @(posedge clock) begin
        if (rst) begin
            rd_src <= lotr_mem_pkg::RD_SRC_NONE;
        end else begin
            rd_src <= rd_src_next;
        end
    end

    // Zero when no read was accepted last cycle
    always_comb begin
        case (rd_src)
            lotr_mem_pkg::RD_SRC_D_MEM: q = d_mem_q;
            lotr_mem_pkg::RD_SRC_CR:    q = cr_q;
            default:                    q = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: lotr_mem_top.sv
// Core ID comes in as a strap and must be stable after reset; one request per cycle, no stall
`default_nettype none

module lotr_mem_top (
    // ===================================================================
    // Clock and reset
    // ===================================================================

    input  logic                  clock,
    // Synchronous, active high
    input  logic                  rst,

    // ===================================================================
    // Core side
    // ===================================================================

    // Request from the core pipeline
    input  lotr_mem_pkg::t_mem_req req,
    // Strap for this core
    input  logic [7:0]            core_id,
    // Read data, one cycle after the read
    output logic [31:0]           q,
    // PC control toward the core
    output lotr_cr_pkg::t_cr      cr
);

    // Data memory side of the core
    // Holds the RAM, the CR file and the read mux
    d_mem_wrap u_d_mem_wrap (
        .clock   (clock),
        .rst     (rst),
        .req     (req),
        .core_id (core_id),
        .q       (q),
        .cr      (cr)
    );

endmodule

`default_nettype wire

// File: tb_clkgen.sv
// Free-running clock from time zero, starts low; PERIOD should be even
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD = 8
) (
    output logic clock
);

    // Low for the first half period
    initial begin
        clock = 1'b0;
    end

    // Toggle every half period
    always #(PERIOD / 2) clock = ~clock;

endmodule

`default_nettype wire

// File: lotr_mem_assert.sv
// Watches only the top-level ports; every assertion failure is also counted in assert_fails
`default_nettype none

`include "lotr_cfg.svh"

module lotr_mem_assert (
    input logic                   clock,
    input logic                   rst,
    input lotr_mem_pkg::t_mem_req req,
    input logic [7:0]             core_id,
    input logic [31:0]            q,
    input lotr_cr_pkg::t_cr       cr
);

    logic                  local_core;
    logic [1:0]            region;
    lotr_mem_pkg::t_rd_src rd_src_exp;
    logic                  cr_write;
    // Failure count, read by the testbench
    int unsigned           assert_fails = 0;

    // ==================================================================
    // Port-level decode
    // ==================================================================

    always_comb begin
        local_core = (req.address[`LOTR_MSB_CORE_ID:`LOTR_LSB_CORE_ID] == 8'd0)
                  || (req.address[`LOTR_MSB_CORE_ID:`LOTR_LSB_CORE_ID] == core_id);
        region     = req.address[`LOTR_MSB_REGION:`LOTR_LSB_REGION];
        rd_src_exp = lotr_mem_pkg::RD_SRC_NONE;
        if (req.rden && local_core && region == `LOTR_D_MEM_REGION) begin
            rd_src_exp = lotr_mem_pkg::RD_SRC_D_MEM;
        end else if (req.rden && local_core && region == `LOTR_CR_REGION) begin
            rd_src_exp = lotr_mem_pkg::RD_SRC_CR;
        end
        cr_write = req.wren && local_core && (region == `LOTR_CR_REGION);
    end

    // ==================================================================
    // Properties
    // ==================================================================

    // No accepted read, so nothing on q next cycle
    q_zero_after_idle: assert property (@(posedge clock) disable iff (rst)
        (rd_src_exp == lotr_mem_pkg::RD_SRC_NONE) |=> (q == '0))
    else begin
        $error("q is not zero after a cycle without an accepted read");
        assert_fails++;
    end

    // Only a local CR write moves cr
    cr_stable_without_write: assert property (@(posedge clock) disable iff (rst)
        !cr_write |=> $stable(cr))
    else begin
        $error("cr changed without a local CR write");
        assert_fails++;
    end

    // Reset clears both PC controls and the read source
    cr_zero_after_reset: assert property (@(posedge clock)
        rst |=> (cr == '0) && (q == '0))
    else begin
        $error("cr or q not zero after a reset cycle");
        assert_fails++;
    end

endmodule

`default_nettype wire

// File: lotr_mem_tb.sv
// Strap is core ID 1; RAM words are written before they are read; q is checked every cycle
`default_nettype none

`include "lotr_cfg.svh"

module lotr_mem_tb;

    localparam logic [7:0] LOCAL_ID      = 8'd1;
    localparam int         RESET_TIMEOUT = 10;
    localparam int         N_WORDS       = 16;

    logic                   clock;
    logic                   rst;
    lotr_mem_pkg::t_mem_req req;
    logic [7:0]             core_id;
    logic [31:0]            q;
    lotr_cr_pkg::t_cr       cr;

    // Shadow model of RAM and CR file
    logic [31:0]      shadow_mem [`LOTR_D_MEM_WORDS];
    lotr_cr_pkg::t_cr shadow_cr;
    // What q must show for last cycle's request
    logic [31:0]      exp_q;
    logic [31:0]      exp_addr;
    int               word_idx [N_WORDS];
    int               errors;
    int               tests_passed;
    int               tests_failed;
    int               errors_at_start;

    tb_clkgen #(.PERIOD(8)) u_clkgen (.clock(clock));

    lotr_mem_top dut0 (
        .clock   (clock),
        .rst     (rst),
        .req     (req),
        .core_id (core_id),
        .q       (q),
        .cr      (cr)
    );

    bind lotr_mem_top lotr_mem_assert u_mem_assert (
        .clock (clock), .rst (rst), .req (req), .core_id (core_id), .q (q), .cr (cr)
    );

    // Reset held over the first 3 rising edges
    // Released on the falling edge after the third
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;
    end

    // ==================================================================
    // Address and request builders
    // ==================================================================

    function automatic logic [31:0] make_addr(input logic [7:0] id, input logic [1:0] region,
                                              input logic [11:0] offset);
        logic [31:0] a;
        a = '0;
        a[`LOTR_MSB_CORE_ID:`LOTR_LSB_CORE_ID] = id;
        a[`LOTR_MSB_REGION:`LOTR_LSB_REGION]   = region;
        a[11:0] = offset;
        return a;
    endfunction

    function automatic logic [31:0] ram_addr(input logic [7:0] id, input int idx);
        return make_addr(id, `LOTR_D_MEM_REGION, 12'(idx * 4));
    endfunction

    function automatic logic [31:0] cr_addr(input logic [7:0] id, input logic [7:0] off);
        return make_addr(id, `LOTR_CR_REGION, {4'b0, off});
    endfunction

    function automatic lotr_mem_pkg::t_mem_req make_req(input logic [31:0] addr,
        input logic [3:0] be, input logic [31:0] data, input logic rd, input logic wr);
        lotr_mem_pkg::t_mem_req r;
        r.address = addr;
        r.byteena = be;
        r.data    = data;
        r.rden    = rd;
        r.wren    = wr;
        return r;
    endfunction

    // Bound assertion failures count too
    function automatic int fail_total();
        return errors + int'(dut0.u_mem_assert.assert_fails);
    endfunction

    // ==================================================================
    // Shadow model
    // ==================================================================

    // Read value taken before this cycle's write
    task automatic update_model(input lotr_mem_pkg::t_mem_req r, output logic [31:0] rd);
        logic       hit;
        logic [1:0] region;
        int         idx;
        logic [7:0] off;
        rd     = '0;
        hit    = (r.address[31:24] == 8'd0) || (r.address[31:24] == LOCAL_ID);
        region = r.address[`LOTR_MSB_REGION:`LOTR_LSB_REGION];
        idx    = int'(r.address[`LOTR_MSB_D_MEM:2]);
        off    = r.address[`LOTR_MSB_CR:0];
        if (hit && region == `LOTR_D_MEM_REGION) begin
            if (r.rden) rd = shadow_mem[idx];
            for (int b = 0; b < 4; b++) begin
                if (r.wren && r.byteena[b]) shadow_mem[idx][8*b +: 8] = r.data[8*b +: 8];
            end
        end else if (hit && region == `LOTR_CR_REGION) begin
            if (r.rden && off == lotr_cr_pkg::CR_EN_PC) rd = {31'b0, shadow_cr.en_pc};
            if (r.rden && off == lotr_cr_pkg::CR_RST_PC) rd = {31'b0, shadow_cr.rst_pc};
            if (r.rden && off == lotr_cr_pkg::CR_CORE_ID) rd = {24'b0, LOCAL_ID};
            if (r.wren && off == lotr_cr_pkg::CR_EN_PC) shadow_cr.en_pc = r.data[0];
            if (r.wren && off == lotr_cr_pkg::CR_RST_PC) shadow_cr.rst_pc = r.data[0];
        end
    endtask

    // ==================================================================
    // Cycle driver and checks
    // ==================================================================

    task automatic check_outputs();
        assert (q === exp_q) else begin
            $display("** Error at %0t: q for address 0x%08h expected 0x%08h, got 0x%08h",
                     $time, exp_addr, exp_q, q);
            errors++;
        end
        assert (cr === shadow_cr) else begin
            $display("** Error at %0t: cr expected %b, got %b", $time, shadow_cr, cr);
            errors++;
        end
    endtask

    // Called on a falling edge, returns on the next one
    task automatic drive(input lotr_mem_pkg::t_mem_req r);
        logic [31:0] rd;
        check_outputs();
        req = r;
        update_model(r, rd);
        exp_q    = rd;
        exp_addr = r.address;
        @(negedge clock);
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [3:0] be,
                              input logic [31:0] data);
        drive(make_req(addr, be, data, 1'b0, 1'b1));
    endtask

    task automatic read_word(input logic [31:0] addr);
        drive(make_req(addr, 4'h0, 32'h0, 1'b1, 1'b0));
    endtask

    task automatic idle();
        drive('0);
    endtask

    // Looks at rst on rising edges, since it moves on falling ones
    task automatic wait_reset_done();
        int cycles;
        cycles = 0;
        while (rst !== 1'b0 && cycles < RESET_TIMEOUT) begin
            @(posedge clock);
            cycles++;
        end
        if (rst !== 1'b0) begin
            $display("Timeout: reset still asserted after %0d cycles", RESET_TIMEOUT);
            $display("Test failures found");
            $finish;
        end
        // Back on the driving edge
        @(negedge clock);
    endtask

    task automatic start_test();
        errors_at_start = fail_total();
    endtask

    // Trailing idle cycle checks the last read
    task automatic finish_test(input string name);
        idle();
        if (fail_total() == errors_at_start) begin
            tests_passed++;
            $display("[%0t] %s: pass", $time, name);
        end else begin
            tests_failed++;
            $display("[%0t] %s: FAIL with %0d errors", $time, name,
                     fail_total() - errors_at_start);
        end
    endtask

    // ==================================================================
    // Test sequence
    // ==================================================================

    initial begin
        logic [31:0] addr;
        void'($urandom(93864));
        req          = '0;
        core_id      = LOCAL_ID;
        shadow_cr    = '0;
        exp_q        = '0;
        exp_addr     = '0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        wait_reset_done();

        start_test();
        idle();
        finish_test("reset");

        // Full words, then back-to-back reads
        start_test();
        for (int i = 0; i < N_WORDS; i++) begin
            word_idx[i] = int'($urandom_range(`LOTR_D_MEM_WORDS - 1));
            write_word(ram_addr(LOCAL_ID, word_idx[i]), 4'hf, $urandom);
        end
        for (int i = 0; i < N_WORDS; i++) begin
            read_word(ram_addr(LOCAL_ID, word_idx[i]));
        end
        finish_test("ram_write_read");

        start_test();
        for (int i = 0; i < N_WORDS; i++) begin
            addr = ram_addr(LOCAL_ID, word_idx[i]);
            write_word(addr, 4'hf, $urandom);
            write_word(addr, 4'($urandom), $urandom);
            read_word(addr);
        end
        // Read and write together, old word comes back
        drive(make_req(addr, 4'h5, $urandom, 1'b1, 1'b1));
        read_word(addr);
        finish_test("byte_enables");

        start_test();
        write_word(cr_addr(LOCAL_ID, lotr_cr_pkg::CR_EN_PC), 4'hf, 32'h1);
        write_word(cr_addr(LOCAL_ID, lotr_cr_pkg::CR_RST_PC), 4'hf, 32'h1);
        read_word(cr_addr(LOCAL_ID, lotr_cr_pkg::CR_EN_PC));
        read_word(cr_addr(LOCAL_ID, lotr_cr_pkg::CR_RST_PC));
        read_word(cr_addr(LOCAL_ID, lotr_cr_pkg::CR_CORE_ID));
        write_word(cr_addr(LOCAL_ID, 8'h0c), 4'hf, 32'hffff_ffff);
        read_word(cr_addr(LOCAL_ID, 8'h0c));
        write_word(cr_addr(LOCAL_ID, lotr_cr_pkg::CR_CORE_ID), 4'hf, 32'h55);
        write_word(cr_addr(LOCAL_ID, lotr_cr_pkg::CR_EN_PC), 4'hf, 32'h0);
        read_word(cr_addr(LOCAL_ID, lotr_cr_pkg::CR_EN_PC));
        finish_test("cr_access");

        // Core 0 aliases us, core 2 is someone else
        start_test();
        write_word(ram_addr(8'd0, word_idx[0]), 4'hf, $urandom);
        read_word(ram_addr(LOCAL_ID, word_idx[0]));
        write_word(ram_addr(8'd2, word_idx[0]), 4'hf, $urandom);
        read_word(ram_addr(8'd0, word_idx[0]));
        read_word(ram_addr(8'd2, word_idx[0]));
        write_word(cr_addr(8'd2, lotr_cr_pkg::CR_EN_PC), 4'hf, 32'h1);
        read_word(cr_addr(8'd2, lotr_cr_pkg::CR_RST_PC));
        read_word(make_addr(LOCAL_ID, 2'd0, 12'h010));
        read_word(make_addr(LOCAL_ID, 2'd3, 12'h010));
        finish_test("core_id_match");

        start_test();
        for (int i = 0; i < 8; i++) begin
            read_word(ram_addr(LOCAL_ID, word_idx[i]));
            read_word(cr_addr(LOCAL_ID, (i % 2 == 0) ? 8'h08 : 8'h04));
        end
        finish_test("mixed_traffic");

        $display("Tests passed: %0d, failed: %0d, check errors: %0d",
                 tests_passed, tests_failed, fail_total());
        if (tests_failed == 0 && fail_total() == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
lotr_mem_pkg.sv
lotr_cr_pkg.sv
d_mem.sv
cr_regs.sv
d_mem_wrap.sv
lotr_mem_top.sv
tb_clkgen.sv
lotr_mem_assert.sv
lotr_mem_tb.sv

// File: Bender.yml
package:
  name: lotr_mem

export_include_dirs:
  - .

sources:
  # Design, in compile order
  - include_dirs:
      - .
    files:
      - lotr_mem_pkg.sv
      - lotr_cr_pkg.sv
      - d_mem.sv
      - cr_regs.sv
      - d_mem_wrap.sv
      - lotr_mem_top.sv

  # Testbench
  - target: test
    include_dirs:
      - .
    files:
      - tb_clkgen.sv
      - lotr_mem_assert.sv
      - lotr_mem_tb.sv
